// ==== src/cdp_word_pkg.sv ====
// packet word definitions
package cdp_word_pkg;

  localparam int WORD_W = 139;  // kind + byte valid + port + payload

  // word kind, upper three bits of every word
  typedef enum logic [2:0] {
    WT_MIDDLE = 3'b100,
    WT_HEAD   = 3'b101,
    WT_TAIL   = 3'b110
  } word_type_t;

  typedef logic [3:0] port_num_t;  // output port number

  // 139-bit packet word, kind in [138:136], port field in [131:128]
  typedef struct packed {
    word_type_t          kind;
    logic [3:0]          byte_valid;  // valid bytes in the tail word
    port_num_t           port;
    logic [WORD_W-12:0]  payload;
  } cdp_word_t;

endpackage

// ==== src/cdp_rule_pkg.sv ====
// forwarding rule and pipeline types
package cdp_rule_pkg;

  localparam int NUM_PORTS = 17;  // 16 fast ports plus the 100M interface

  typedef logic [NUM_PORTS-1:0] port_mask_t;

  typedef enum logic [3:0] {
    CMD_FORWARD = 4'd0,
    CMD_DISCARD = 4'd1,
    CMD_CUT     = 4'd2
  } rule_cmd_t;

  // 30-bit rule word as written by the user module
  typedef struct packed {
    logic       src;      // data source, not used here
    rule_cmd_t  cmd;
    logic [7:0] cut_len;
    port_mask_t mask;
  } cdp_rule_t;

  typedef struct packed {
    rule_cmd_t               cmd;
    cdp_word_pkg::port_num_t port;     // lowest set mask bit below 16
    logic [7:0]              cut_len;
    port_mask_t              mask;
  } decision_t;

  typedef enum logic [1:0] {
    DESC_NORMAL = 2'b10,  // forward on port held in head word
    DESC_COPY   = 2'b11   // forward to every port in the mask
  } desc_kind_t;

  typedef struct packed {
    desc_kind_t kind;
    port_mask_t mask;
  } pkt_desc_t;

  typedef enum logic [1:0] {
    ACT_KEEP,
    ACT_KEEP_PORT,  // head word, port field rewritten
    ACT_KEEP_LAST,  // cut point, rewritten as tail
    ACT_DROP
  } word_action_t;

  typedef struct packed {
    cdp_word_pkg::cdp_word_t word;
    word_action_t            action;
    pkt_desc_t               desc;
    logic                    last;  // last kept word of the packet
  } stage_t;

endpackage

// ==== src/sync_fifo.sv ====
// show-ahead synchronous FIFO
module sync_fifo #(
  parameter int  DEPTH     = 32,
  parameter type payload_t = logic
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     push,
  input  payload_t                 data,
  input  logic                     pop,
  output payload_t                 q,
  output logic                     empty,
  output logic [$clog2(DEPTH)-1:0] usedw
);

  localparam int AW = $clog2(DEPTH);

  payload_t mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          full;
  logic          do_push;
  logic          do_pop;

  assign full    = count[AW];
  assign empty   = (count == '0);
  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || do_pop);  // writes to a full FIFO are lost
  assign q       = mem[rd_ptr];                 // head word always visible
  assign usedw   = count[AW-1:0];               // reads 0 when full

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= data;
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps with DEPTH a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/rule_decoder.sv ====
// rule to forwarding decision
module rule_decoder (
  input  cdp_rule_pkg::cdp_rule_t rule,
  output cdp_rule_pkg::decision_t decision
);

  import cdp_word_pkg::*;
  import cdp_rule_pkg::*;

  port_num_t port;

  // lowest set bit among the 16 fast ports wins
  always_comb
  begin
    port = '0;  // also the 100M-only case
    for (int i = 15; i >= 0; i--)
    begin
      if (rule.mask[i])
        port = port_num_t'(i);
    end
  end

  always_comb
  begin
    decision.port    = port;
    decision.cut_len = rule.cut_len;
    decision.mask    = rule.mask;
    case (rule.cmd)
      CMD_FORWARD: decision.cmd = CMD_FORWARD;
      CMD_CUT:     decision.cmd = CMD_CUT;
      default:     decision.cmd = CMD_DISCARD;  // unknown commands drop the packet
    endcase
  end

endmodule

// ==== src/dispatch_ctrl.sv ====
// per-packet dispatch FSM
module dispatch_ctrl #(
  parameter int SPACE_LIMIT = 161,
  parameter int CUT_EXTRA   = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    rule_empty,
  input  cdp_rule_pkg::decision_t decision,
  input  logic                    pkt_empty,
  input  cdp_word_pkg::cdp_word_t pkt_word,
  input  logic [7:0]              pkt_data_usedw,
  output logic                    rule_pop,
  output logic                    pkt_pop,
  output logic                    stage_valid,
  output cdp_rule_pkg::stage_t    stage
);

  import cdp_word_pkg::*;
  import cdp_rule_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT_RULE,
    S_STREAM,
    S_DRAIN
  } state_t;

  state_t     state;
  state_t     state_next;
  decision_t  dec_q;     // decision for the packet in flight
  logic [8:0] word_cnt;  // words kept so far under cut
  logic [8:0] cut_last;
  logic       is_tail;
  logic       at_limit;

  assign cut_last = {1'b0, dec_q.cut_len} + 9'(CUT_EXTRA - 1);
  assign is_tail  = (pkt_word.kind == WT_TAIL);
  assign at_limit = (dec_q.cmd == CMD_CUT) && (word_cnt == cut_last);

  assign rule_pop    = (state == S_WAIT_RULE) && !rule_empty;
  assign pkt_pop     = ((state == S_STREAM) || (state == S_DRAIN)) && !pkt_empty;
  assign stage_valid = pkt_pop;  // dropped words are tagged, editor ignores them

  always_comb
  begin
    stage.word      = pkt_word;
    stage.desc.kind = (dec_q.cmd == CMD_FORWARD) ? DESC_COPY : DESC_NORMAL;
    stage.desc.mask = dec_q.mask;
    stage.action    = ACT_DROP;
    stage.last      = 1'b0;
    if (state == S_STREAM)
    begin
      if (at_limit)
        stage.action = ACT_KEEP_LAST;
      else if ((dec_q.cmd == CMD_CUT) && (pkt_word.kind == WT_HEAD))
      begin
        stage.action    = ACT_KEEP_PORT;
        stage.word.port = dec_q.port;  // selected port into the head word
      end
      else
        stage.action = ACT_KEEP;  // a short cut packet keeps its own tail
      stage.last = at_limit || is_tail;
    end
  end

  always_comb
  begin
    state_next = state;
    case (state)
      S_IDLE:
        if (pkt_data_usedw < SPACE_LIMIT)  // room for a full packet
          state_next = S_WAIT_RULE;
      S_WAIT_RULE:
        if (!rule_empty)
          state_next = (decision.cmd == CMD_DISCARD) ? S_DRAIN : S_STREAM;
      S_STREAM:
        if (pkt_pop)
        begin
          if (is_tail)
            state_next = S_IDLE;
          else if (at_limit)
            state_next = S_DRAIN;  // drop the rest of a cut packet
        end
      S_DRAIN:
        if (pkt_pop && is_tail)
          state_next = S_IDLE;
      default:
        state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      state    <= S_IDLE;
      word_cnt <= '0;
    end
    else
    begin
      state <= state_next;
      if (rule_pop)
        word_cnt <= '0;
      else if ((state == S_STREAM) && pkt_pop)
        word_cnt <= word_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rule_pop)
      dec_q <= decision;  // latched with the rule pop
  end

endmodule

// ==== src/word_editor.sv ====
// output word rewrite stage
module word_editor (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stage_valid,
  input  cdp_rule_pkg::stage_t      stage,
  output logic                      pkt_data_wrreq,
  output cdp_word_pkg::cdp_word_t   pkt_data,
  output logic                      pkt_valid_wrreq,
  output cdp_rule_pkg::pkt_desc_t   pkt_valid
);

  import cdp_word_pkg::*;
  import cdp_rule_pkg::*;

  cdp_word_t edited;
  logic      keep;

  assign keep = stage_valid && (stage.action != ACT_DROP);

  always_comb
  begin
    edited = stage.word;  // head port already set by the dispatcher
    case (stage.action)
      ACT_KEEP_LAST:
      begin
        edited.kind       = WT_TAIL;
        edited.byte_valid = 4'hf;  // whole word valid at the cut point
      end
      default:
        edited = stage.word;
    endcase
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      pkt_data_wrreq  <= 1'b0;
      pkt_valid_wrreq <= 1'b0;
    end
    else
    begin
      pkt_data_wrreq  <= keep;
      pkt_valid_wrreq <= keep && stage.last;  // descriptor with last kept word
    end
  end

  always_ff @(posedge clk)
  begin
    if (keep)
      pkt_data <= edited;
    if (keep && stage.last)
      pkt_valid <= stage.desc;
  end

endmodule

// ==== src/output_ctrl.sv ====
// output controller top level
module output_ctrl #(
  parameter int PKT_FIFO_DEPTH  = 256,
  parameter int RULE_FIFO_DEPTH = 32,
  parameter int SPACE_LIMIT     = 161,
  parameter int CUT_EXTRA       = 4
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               input2output_wrreq,
  input  cdp_word_pkg::cdp_word_t            input2output_data,
  output logic [$clog2(PKT_FIFO_DEPTH)-1:0]  input2output_usedw,
  input  logic                               um2cdp_rule_wrreq,
  input  cdp_rule_pkg::cdp_rule_t            um2cdp_rule,
  output logic [$clog2(RULE_FIFO_DEPTH)-1:0] cdp2um_rule_usedw,
  output logic                               pkt_data_wrreq,
  output cdp_word_pkg::cdp_word_t            pkt_data,
  output logic                               pkt_valid_wrreq,
  output cdp_rule_pkg::pkt_desc_t            pkt_valid,
  input  logic [7:0]                         pkt_data_usedw
);

  import cdp_word_pkg::*;
  import cdp_rule_pkg::*;

  cdp_rule_t rule_q;
  logic      rule_empty;
  logic      rule_pop;
  decision_t decision;
  cdp_word_t pkt_q;
  logic      pkt_empty;
  logic      pkt_pop;
  logic      stage_valid;
  stage_t    stage;

  sync_fifo #(
    .DEPTH     (RULE_FIFO_DEPTH),
    .payload_t (cdp_rule_t)
  ) u_rule_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (um2cdp_rule_wrreq),
    .data  (um2cdp_rule),
    .pop   (rule_pop),
    .q     (rule_q),
    .empty (rule_empty),
    .usedw (cdp2um_rule_usedw)
  );

  sync_fifo #(
    .DEPTH     (PKT_FIFO_DEPTH),
    .payload_t (cdp_word_t)
  ) u_pkt_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (input2output_wrreq),
    .data  (input2output_data),
    .pop   (pkt_pop),
    .q     (pkt_q),
    .empty (pkt_empty),
    .usedw (input2output_usedw)
  );

  rule_decoder u_rule_decoder (
    .rule     (rule_q),
    .decision (decision)
  );

  dispatch_ctrl #(
    .SPACE_LIMIT (SPACE_LIMIT),
    .CUT_EXTRA   (CUT_EXTRA)
  ) u_dispatch_ctrl (
    .clk            (clk),
    .reset          (reset),
    .rule_empty     (rule_empty),
    .decision       (decision),
    .pkt_empty      (pkt_empty),
    .pkt_word       (pkt_q),
    .pkt_data_usedw (pkt_data_usedw),
    .rule_pop       (rule_pop),
    .pkt_pop        (pkt_pop),
    .stage_valid    (stage_valid),
    .stage          (stage)
  );

  word_editor u_word_editor (
    .clk             (clk),
    .reset           (reset),
    .stage_valid     (stage_valid),
    .stage           (stage),
    .pkt_data_wrreq  (pkt_data_wrreq),
    .pkt_data        (pkt_data),
    .pkt_valid_wrreq (pkt_valid_wrreq),
    .pkt_valid       (pkt_valid)
  );

endmodule

// ==== tests/output_ctrl_tb.sv ====
// output controller testbench
module output_ctrl_tb;

  import cdp_word_pkg::*;
  import cdp_rule_pkg::*;

  localparam int CLK_PERIOD = 20;

  logic        clk;
  logic        reset;
  logic        input2output_wrreq;
  cdp_word_t   input2output_data;
  logic [7:0]  input2output_usedw;
  logic        um2cdp_rule_wrreq;
  cdp_rule_t   um2cdp_rule;
  logic [4:0]  cdp2um_rule_usedw;
  logic        pkt_data_wrreq;
  cdp_word_t   pkt_data;
  logic        pkt_valid_wrreq;
  pkt_desc_t   pkt_valid;
  logic [7:0]  pkt_data_usedw;

  cdp_word_t   pkt_buf [64];  // packet being sent
  cdp_word_t   exp_words [$];
  pkt_desc_t   exp_descs [$];
  logic [31:0] rng_state = 32'h3bb43d13;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          err_base = 0;
  int          words_sent = 0;
  int          cycles = 0;
  string       test_name;

  output_ctrl #(
    .PKT_FIFO_DEPTH  (256),
    .RULE_FIFO_DEPTH (32),
    .SPACE_LIMIT     (161),
    .CUT_EXTRA       (4)
  ) DUT (
    .clk                (clk),
    .reset              (reset),
    .input2output_wrreq (input2output_wrreq),
    .input2output_data  (input2output_data),
    .input2output_usedw (input2output_usedw),
    .um2cdp_rule_wrreq  (um2cdp_rule_wrreq),
    .um2cdp_rule        (um2cdp_rule),
    .cdp2um_rule_usedw  (cdp2um_rule_usedw),
    .pkt_data_wrreq     (pkt_data_wrreq),
    .pkt_data           (pkt_data),
    .pkt_valid_wrreq    (pkt_valid_wrreq),
    .pkt_valid          (pkt_valid),
    .pkt_data_usedw     (pkt_data_usedw)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic port_num_t lowest_port(input port_mask_t mask);
    for (int i = 0; i < 16; i++)
    begin
      if (mask[i])
        return port_num_t'(i);
    end
    return '0;  // no fast port in the mask
  endfunction

  function automatic cdp_rule_t make_rule(input logic [3:0] cmd, input logic [7:0] cut_len,
                                          input port_mask_t mask);
    cdp_rule_t r;
    r.src     = 1'(rand32());  // ignored by the DUT
    r.cmd     = rule_cmd_t'(cmd);
    r.cut_len = cut_len;
    r.mask    = mask;
    return r;
  endfunction

  function automatic void build_packet(input int len, input port_num_t head_port);
    for (int i = 0; i < len; i++)
    begin
      pkt_buf[i].payload    = {rand32(), rand32(), rand32(), rand32()};
      pkt_buf[i].byte_valid = 4'(rand32());
      pkt_buf[i].port       = 4'(rand32());
      pkt_buf[i].kind       = (i == 0) ? WT_HEAD : ((i == len - 1) ? WT_TAIL : WT_MIDDLE);
    end
    pkt_buf[0].port = head_port;
  endfunction

  // expected output of one packet under one rule
  function automatic void model_packet(input cdp_rule_t rule, input int len);
    cdp_word_t w;
    pkt_desc_t d;
    int        limit;
    limit  = rule.cut_len + 4;
    d.mask = rule.mask;
    if (rule.cmd == CMD_FORWARD)
    begin
      for (int i = 0; i < len; i++)
        exp_words.push_back(pkt_buf[i]);
      d.kind = DESC_COPY;
      exp_descs.push_back(d);
    end
    else if (rule.cmd == CMD_CUT)
    begin
      for (int i = 0; i < len && i < limit; i++)
      begin
        w = pkt_buf[i];
        if (i == 0)
          w.port = lowest_port(rule.mask);
        if (i == limit - 1)
        begin
          w.kind       = WT_TAIL;  // cut point
          w.byte_valid = 4'hf;
        end
        exp_words.push_back(w);
      end
      d.kind = DESC_NORMAL;
      exp_descs.push_back(d);
    end
    // every other command drops the packet
  endfunction

  task automatic check_equal(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                             input string msg);
    checks++;
    if (got !== exp)
    begin
      $display("Fail at time %0t: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic send_rule(input cdp_rule_t rule);
    @(posedge clk);
    um2cdp_rule_wrreq <= 1'b1;
    um2cdp_rule       <= rule;
    @(posedge clk);
    um2cdp_rule_wrreq <= 1'b0;
  endtask

  task automatic send_packet(input int len);
    for (int i = 0; i < len; i++)
    begin
      @(posedge clk);
      input2output_wrreq <= 1'b1;
      input2output_data  <= pkt_buf[i];
    end
    @(posedge clk);
    input2output_wrreq <= 1'b0;
    words_sent += len;
  endtask

  task automatic queue_packet(input cdp_rule_t rule, input int len);
    port_num_t head_port;
    head_port = port_num_t'(rand32());  // upstream port tag, rewritten only under cut
    build_packet(len, head_port);
    model_packet(rule, len);
    send_rule(rule);
    send_packet(len);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_base  = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("test %s done, %0d errors", test_name, errors - err_base);
  endtask

  task automatic wait_drain();
    while (exp_words.size() != 0 || exp_descs.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);  // room for stray strobes
  endtask

  always @(negedge clk)
  begin
    if (pkt_data_wrreq === 1'b1)
    begin
      if (exp_words.size() == 0)
      begin
        $display("unexpected output word at time %0t, nothing was expected", $time);
        errors++;
      end
      else
        check_equal(pkt_data, exp_words.pop_front(), "output word");
    end
    if (pkt_valid_wrreq === 1'b1)
    begin
      if (exp_descs.size() == 0)
      begin
        $display("unexpected descriptor at time %0t, nothing was expected", $time);
        errors++;
      end
      else
        check_equal(pkt_valid, exp_descs.pop_front(), "descriptor");
    end
  end

  initial
  begin
    while (cycles <= words_sent * 40 + 2000)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d words sent", cycles, words_sent);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    clk                = 1'b0;
    reset              = 1'b0;
    input2output_wrreq = 1'b0;
    input2output_data  = '0;
    um2cdp_rule_wrreq  = 1'b0;
    um2cdp_rule        = '0;
    pkt_data_usedw     = 8'd161;  // downstream full from the start
    repeat (2) @(posedge clk);
    reset <= 1'b1;

    start_test("fill_levels");
    queue_packet(make_rule(CMD_FORWARD, 8'd0, port_mask_t'(rand32())), 6);
    queue_packet(make_rule(CMD_CUT, 8'd1, port_mask_t'(rand32())), 9);
    queue_packet(make_rule(CMD_DISCARD, 8'd0, port_mask_t'(rand32())), 4);
    queue_packet(make_rule(CMD_FORWARD, 8'd0, port_mask_t'(rand32())), 3);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_equal(input2output_usedw, 22, "packet FIFO fill level");
    check_equal(cdp2um_rule_usedw, 4, "rule FIFO fill level");
    end_test();

    start_test("space_gating");
    repeat (40)
    begin
      @(negedge clk);
      if (pkt_data_wrreq || pkt_valid_wrreq)
      begin
        $display("output at time %0t while downstream space was short", $time);
        errors++;
      end
    end
    @(posedge clk);
    pkt_data_usedw <= 8'd0;
    wait_drain();
    end_test();

    start_test("forward");
    for (int n = 0; n < 8; n++)
      queue_packet(make_rule(CMD_FORWARD, 8'(rand32()), port_mask_t'(rand32())),
                   3 + rand32() % 8);
    wait_drain();
    end_test();

    start_test("discard");
    queue_packet(make_rule(CMD_DISCARD, 8'd0, port_mask_t'(rand32())), 5);
    queue_packet(make_rule(4'd7, 8'd0, port_mask_t'(rand32())), 7);  // unused command
    queue_packet(make_rule(CMD_FORWARD, 8'd0, port_mask_t'(rand32())), 4);
    wait_drain();
    end_test();

    start_test("cut");
    queue_packet(make_rule(CMD_CUT, 8'd3, port_mask_t'(rand32()) | 17'h00010), 20);
    queue_packet(make_rule(CMD_CUT, 8'd2, 17'h10000), 12);  // 100M port only
    queue_packet(make_rule(CMD_CUT, 8'd1, port_mask_t'(rand32())), 5);  // tail at cut point
    queue_packet(make_rule(CMD_FORWARD, 8'd0, port_mask_t'(rand32())), 6);
    wait_drain();
    end_test();

    start_test("short_cut");
    queue_packet(make_rule(CMD_CUT, 8'd10, port_mask_t'(rand32())), 5);
    queue_packet(make_rule(CMD_CUT, 8'd200, port_mask_t'(rand32())), 9);
    queue_packet(make_rule(CMD_FORWARD, 8'd0, port_mask_t'(rand32())), 3);
    wait_drain();
    end_test();

    repeat (10) @(posedge clk);
    if (exp_words.size() != 0 || exp_descs.size() != 0)
    begin
      $display("output missing at end of run: %0d words and %0d descriptors never came",
               exp_words.size(), exp_descs.size());
      errors++;
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== files.f ====
src/cdp_word_pkg.sv
src/cdp_rule_pkg.sv
src/sync_fifo.sv
src/rule_decoder.sv
src/dispatch_ctrl.sv
src/word_editor.sv
src/output_ctrl.sv
tests/output_ctrl_tb.sv
